//--- verilog/env_pkg.sv
/*
 * Envelope generator shared definitions.
 * Sizes, slot and register types, phase encoding,
 * per-slot state record, step pair and small helpers.
 */
package env_pkg;

    localparam int VOICES    = 4;
    localparam int ENVS      = 2;
    localparam int SLOTS     = VOICES * ENVS;
    localparam int MAIN_ENV  = 1;    // main-volume envelope
    localparam int NUM_SHIFT = 22;
    localparam int LEVEL_LSB = 29;   // output byte position in acc
    localparam int ACC_W     = 37;

    typedef logic [1:0] voice_t;
    typedef logic [0:0] env_t;

    typedef struct packed {
        voice_t voice;
        env_t   env;
    } slot_t;

    typedef logic [6:0]              param_adr_t;   // {env, index}
    typedef logic [7:0]              param_byte_t;
    typedef logic signed [7:0]       level_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [VOICES-1:0]       voice_mask_t;

    typedef struct packed {
        param_byte_t [3:0] rate;
        level_t      [3:0] level;
    } param_set_t;

    // order matters, each RATEn is followed by its LEVELn
    typedef enum logic [3:0] {
        IDLE, RATE1, LEVEL1, RATE2, LEVEL2, RATE3, LEVEL3, RATE4, LEVEL4
    } phase_t;

    typedef struct packed {
        phase_t phase;
        acc_t   acc;
        level_t start;   // top byte at phase entry
    } slot_state_t;

    typedef struct packed {
        acc_t step;
        acc_t cand;
    } env_step_t;

    // rate/level index that belongs to a phase
    function automatic logic [1:0] phase_idx(phase_t ph);
        logic [1:0] idx;
        case (ph)
            RATE2, LEVEL2: idx = 2'd1;
            RATE3, LEVEL3: idx = 2'd2;
            RATE4, LEVEL4: idx = 2'd3;
            default:       idx = 2'd0;
        endcase
        return idx;
    endfunction

    function automatic level_t top_byte(acc_t a);
        return level_t'(a[ACC_W-1 -: 8]);
    endfunction

endpackage

//--- verilog/env_param_bank.sv
/*
 * Rate and level register bank, per envelope.
 * Byte writes, registered read-back, and the
 * per-cycle parameter set fetch for stage 1.
 */
module env_param_bank (
    input  logic                 sCLK_XVXENVS,
    input  logic                 reset_data_N,
    input  logic                 reg_write,
    input  logic                 reg_read,
    input  env_pkg::param_adr_t  reg_adr,
    input  env_pkg::param_byte_t reg_wdata,
    output env_pkg::param_byte_t reg_rdata,
    input  env_pkg::env_t        fetch_env,
    output env_pkg::param_set_t  fetch_set
);
    import env_pkg::*;

    param_byte_t rate_q  [ENVS][4];
    level_t      level_q [ENVS][4];
    logic        adr_hit;
    env_t        adr_env;
    logic [1:0]  adr_idx;
    logic        adr_lvl;

    assign adr_hit = reg_adr[6:3] < 4'(ENVS);
    assign adr_env = reg_adr[3 +: $bits(env_t)];
    assign adr_idx = reg_adr[1:0];
    assign adr_lvl = reg_adr[2];   // index 4..7 are levels

    always_ff @(posedge sCLK_XVXENVS or negedge reset_data_N) begin
        if (!reset_data_N) begin
            for (int e = 0; e < ENVS; e++) begin
                for (int i = 0; i < 4; i++) begin
                    rate_q[e][i]  <= '0;
                    level_q[e][i] <= (i == 2) ? 8'sh7f : 8'sh00;   // sustain level
                end
            end
        end else if (reg_write && adr_hit) begin
            if (adr_lvl) begin
                level_q[adr_env][adr_idx] <= level_t'(reg_wdata);
            end else begin
                rate_q[adr_env][adr_idx] <= reg_wdata;
            end
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge reset_data_N) begin
        if (!reset_data_N) begin
            reg_rdata <= '0;
        end else if (reg_read) begin
            if (!adr_hit) begin
                reg_rdata <= '0;   // unmapped
            end else if (adr_lvl) begin
                reg_rdata <= param_byte_t'(level_q[adr_env][adr_idx]);
            end else begin
                reg_rdata <= rate_q[adr_env][adr_idx];
            end
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        for (int i = 0; i < 4; i++) begin
            fetch_set.rate[i]  <= rate_q[fetch_env][i];
            fetch_set.level[i] <= level_q[fetch_env][i];
        end
    end

endmodule

//--- verilog/env_state_ram.sv
/*
 * Per-slot envelope state memory.
 * Synchronous read with write-through, writeback port,
 * start-up sweep that clears every slot before ready.
 */
module env_state_ram (
    input  logic                 sCLK_XVXENVS,
    input  logic                 reset_data_N,
    input  env_pkg::slot_t       rd_slot,
    output env_pkg::slot_state_t rd_state,
    input  logic                 wr_en,
    input  env_pkg::slot_t       wr_slot,
    input  env_pkg::slot_state_t wr_state,
    output logic                 ready
);
    import env_pkg::*;

    slot_state_t mem [SLOTS];
    slot_t       clr_adr;
    logic        clearing;

    // sweep pointer, one slot per clock
    always_ff @(posedge sCLK_XVXENVS or negedge reset_data_N) begin
        if (!reset_data_N) begin
            clearing <= 1'b1;
            clr_adr  <= '0;
        end else if (clearing) begin
            clr_adr <= slot_t'(clr_adr + 1'b1);
            if (clr_adr == slot_t'(SLOTS - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    assign ready = ~clearing;

    always_ff @(posedge sCLK_XVXENVS) begin
        if (clearing) begin
            mem[clr_adr] <= '{phase: IDLE, acc: '0, start: '0};
        end else if (wr_en) begin
            mem[wr_slot] <= wr_state;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (wr_en && !clearing && wr_slot == rd_slot) begin
            rd_state <= wr_state;   // slot revisited two cycles on
        end else begin
            rd_state <= mem[rd_slot];
        end
    end

endmodule

//--- verilog/env_step_calc.sv
/*
 * Stage two of the slot pipeline.
 * Picks rate and target for the phase, divides the
 * level distance by rate squared, forms the candidate.
 */
module env_step_calc (
    input  env_pkg::slot_state_t state,
    input  env_pkg::param_set_t  params,
    output env_pkg::env_step_t   step_out
);
    import env_pkg::*;

    logic [1:0]        idx;
    param_byte_t       rate;
    level_t            target;
    logic signed [8:0] diff;
    logic [15:0]       rate_sq;
    acc_t              numer;
    acc_t              denom;
    acc_t              step;

    assign idx     = phase_idx(state.phase);
    assign rate    = params.rate[idx];
    assign target  = params.level[idx];
    assign diff    = 9'(target) - 9'(state.start);   // -255..255
    assign rate_sq = 16'(rate) * 16'(rate);

    assign numer = acc_t'(diff) <<< NUM_SHIFT;
    assign denom = acc_t'(rate_sq);          // zero extended so always positive

    // signed quotient truncates toward zero
    always_comb begin
        if (rate == '0) begin
            step = '0;
        end else begin
            step = numer / denom;
        end
    end

    assign step_out.step = step;
    assign step_out.cand = state.acc + step;

endmodule

//--- verilog/env_phase_fsm.sv
/*
 * Stage three of the slot pipeline.
 * Phase transitions per slot, level_mul register,
 * voice_free flags and the writeback record.
 */
module env_phase_fsm (
    input  logic                 sCLK_XVXENVS,
    input  logic                 reset_data_N,
    input  logic                 valid,
    input  env_pkg::slot_t       slot,
    input  env_pkg::voice_mask_t keys_on,
    input  env_pkg::slot_state_t state,
    input  env_pkg::param_set_t  params,
    input  env_pkg::env_step_t   step_in,
    output logic                 wr_en,
    output env_pkg::slot_t       wr_slot,
    output env_pkg::slot_state_t wr_state,
    output env_pkg::level_t      level_mul,
    output env_pkg::voice_mask_t voice_free
);
    import env_pkg::*;

    logic        key;
    logic [1:0]  idx;
    param_byte_t rate;
    level_t      target;
    level_t      cur_top;
    acc_t        target_acc;
    logic        ramping;
    slot_state_t nxt;

    assign key        = keys_on[slot.voice];
    assign idx        = phase_idx(state.phase);
    assign rate       = params.rate[idx];
    assign target     = params.level[idx];
    assign cur_top    = top_byte(state.acc);
    assign target_acc = {target, {LEVEL_LSB{1'b0}}};
    assign ramping    = (rate != '0) && (top_byte(step_in.cand) != target);   // not there yet

    always_comb begin
        nxt = state;
        case (state.phase)
            IDLE: begin
                if (key) begin
                    nxt.acc   = '0;
                    nxt.phase = RATE1;
                end
            end
            RATE1, RATE2, RATE3: begin
                if (!key) begin
                    nxt.phase = RATE4;   // release
                end else if (ramping) begin
                    nxt.acc = step_in.cand;
                end else begin
                    nxt.acc   = target_acc;
                    nxt.phase = phase_t'(state.phase + 1'b1);   // matching LEVELn
                end
            end
            LEVEL1, LEVEL2: begin
                if (!key) begin
                    nxt.phase = RATE4;
                end else begin
                    nxt.phase = phase_t'(state.phase + 1'b1);   // next rate
                end
            end
            LEVEL3: begin
                if (!key) begin
                    nxt.phase = RATE4;
                end
            end
            RATE4: begin
                if (key) begin
                    nxt.phase = RATE1;   // retrigger from current level
                end else if (ramping) begin
                    nxt.acc = step_in.cand;
                end else begin
                    nxt.acc   = target_acc;
                    nxt.phase = LEVEL4;
                end
            end
            LEVEL4: begin
                if (key) begin
                    nxt.phase = RATE1;
                end else if (target == 8'sh00) begin
                    nxt.acc   = '0;
                    nxt.phase = IDLE;
                end
            end
            default: nxt = '{phase: IDLE, acc: '0, start: '0};
        endcase
        if (nxt.phase != state.phase) begin
            nxt.start = cur_top;
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge reset_data_N) begin
        if (!reset_data_N) begin
            wr_en      <= 1'b0;
            level_mul  <= '0;
            voice_free <= '1;
        end else begin
            wr_en <= valid;
            if (valid) begin
                level_mul <= top_byte(nxt.acc);
                if (slot.env == env_t'(MAIN_ENV)) begin
                    voice_free[slot.voice] <= (nxt.phase == IDLE) || (nxt.phase == LEVEL4);
                end
            end
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        wr_slot  <= slot;
        wr_state <= nxt;
    end

endmodule

//--- verilog/env_gen_top.sv
/*
 * Envelope generator top level.
 * Slot fetch, step calculation and phase update
 * stages, plus the slot tag delay between them.
 */
module env_gen_top (
    input  logic                 sCLK_XVXENVS,
    input  logic                 reset_data_N,
    input  logic                 reg_write,
    input  logic                 reg_read,
    input  env_pkg::param_adr_t  reg_adr,
    input  env_pkg::param_byte_t reg_wdata,
    output env_pkg::param_byte_t reg_rdata,
    input  env_pkg::slot_t       slot,
    input  env_pkg::voice_mask_t keys_on,
    output env_pkg::level_t      level_mul,
    output env_pkg::voice_mask_t voice_free,
    output logic                 ready
);
    import env_pkg::*;

    slot_t       slot_q;   // tag alongside stage-1 registers
    logic        valid_q;
    slot_state_t cur_state;
    param_set_t  cur_params;
    env_step_t   step;
    logic        wr_en;
    slot_t       wr_slot;
    slot_state_t wr_state;

    always_ff @(posedge sCLK_XVXENVS or negedge reset_data_N) begin
        if (!reset_data_N) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ready;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        slot_q <= slot;
    end

    env_param_bank u_param_bank (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset_data_N (reset_data_N),
        .reg_write    (reg_write),
        .reg_read     (reg_read),
        .reg_adr      (reg_adr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .fetch_env    (slot.env),
        .fetch_set    (cur_params)
    );

    env_state_ram u_state_ram (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset_data_N (reset_data_N),
        .rd_slot      (slot),
        .rd_state     (cur_state),
        .wr_en        (wr_en),
        .wr_slot      (wr_slot),
        .wr_state     (wr_state),
        .ready        (ready)
    );

    env_step_calc u_step_calc (
        .state    (cur_state),
        .params   (cur_params),
        .step_out (step)
    );

    env_phase_fsm u_phase_fsm (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset_data_N (reset_data_N),
        .valid        (valid_q),
        .slot         (slot_q),
        .keys_on      (keys_on),
        .state        (cur_state),
        .params       (cur_params),
        .step_in      (step),
        .wr_en        (wr_en),
        .wr_slot      (wr_slot),
        .wr_state     (wr_state),
        .level_mul    (level_mul),
        .voice_free   (voice_free)
    );

endmodule

//--- sim/env_clock_gen.sv
/*
 * Testbench clock and active-low reset source.
 */
module env_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic sCLK_XVXENVS,
    output logic reset_data_N
);
    timeunit 1ns;
    timeprecision 1ps;

    initial sCLK_XVXENVS = 1'b0;
    always #(PERIOD_NS / 2) sCLK_XVXENVS = ~sCLK_XVXENVS;

    initial begin
        reset_data_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge sCLK_XVXENVS);
        #5 reset_data_N = 1'b1;   // released off the edge
    end

endmodule

//--- sim/env_model.svh
/*
 * Reference model of the envelope generator.
 * Register image, per-slot phase state and voice_free image.
 */
param_byte_t m_img   [ENVS][8];   // 0..3 rates, 4..7 levels
phase_t      m_phase [SLOTS];
acc_t        m_acc   [SLOTS];
level_t      m_start [SLOTS];
voice_mask_t m_free;

function automatic level_t acc_level(acc_t a);
    return level_t'(a[36:29]);
endfunction

function automatic void model_reset();
    for (int e = 0; e < ENVS; e++) begin
        for (int i = 0; i < 8; i++) begin
            m_img[e][i] = (i == 6) ? 8'h7f : 8'h00;
        end
    end
    for (int s = 0; s < SLOTS; s++) begin
        m_phase[s] = IDLE;
        m_acc[s]   = '0;
        m_start[s] = '0;
    end
    m_free = '1;
endfunction

function automatic param_byte_t model_read(param_adr_t adr);
    if (adr[6:3] >= 4'(ENVS)) begin
        return 8'h00;
    end
    return m_img[adr[3]][adr[2:0]];
endfunction

function automatic void model_write(param_adr_t adr, param_byte_t wd);
    if (adr[6:3] < 4'(ENVS)) begin
        m_img[adr[3]][adr[2:0]] = wd;
    end
endfunction

// one slot visit with its expected outputs
function automatic void model_visit(slot_t s, voice_mask_t keys,
                                    output level_t lvl, output voice_mask_t fr);
    int          n;
    logic        key;
    logic [1:0]  k;
    param_byte_t rate;
    level_t      target;
    longint      diff;
    acc_t        step;
    acc_t        cand;
    acc_t        tacc;
    logic        ramp;
    phase_t      ph;
    phase_t      nph;
    acc_t        nacc;
    n   = int'(s);
    key = keys[s.voice];
    ph  = m_phase[n];
    case (ph)
        RATE2, LEVEL2: k = 2'd1;
        RATE3, LEVEL3: k = 2'd2;
        RATE4, LEVEL4: k = 2'd3;
        default:       k = 2'd0;
    endcase
    rate   = m_img[s.env][{1'b0, k}];
    target = level_t'(m_img[s.env][{1'b1, k}]);
    diff   = longint'(target) - longint'(m_start[n]);
    if (rate == 8'h00) begin
        step = '0;
    end else begin
        step = acc_t'((diff * (longint'(1) <<< NUM_SHIFT)) /
                      (longint'(rate) * longint'(rate)));
    end
    cand = m_acc[n] + step;
    tacc = {target, 29'b0};
    ramp = (rate != 8'h00) && (acc_level(cand) != target);
    nph  = ph;
    nacc = m_acc[n];
    case (ph)
        IDLE: begin
            if (key) begin
                nph  = RATE1;
                nacc = '0;
            end
        end
        RATE1, RATE2, RATE3, RATE4: begin
            if (key != (ph != RATE4)) begin
                nph = (ph == RATE4) ? RATE1 : RATE4;   // retrigger or release
            end else if (ramp) begin
                nacc = cand;
            end else begin
                nacc = tacc;
                nph  = (ph == RATE1) ? LEVEL1 : (ph == RATE2) ? LEVEL2 :
                       (ph == RATE3) ? LEVEL3 : LEVEL4;
            end
        end
        LEVEL1: nph = key ? RATE2 : RATE4;
        LEVEL2: nph = key ? RATE3 : RATE4;
        LEVEL3: if (!key) nph = RATE4;
        default: begin   // LEVEL4
            if (key) begin
                nph = RATE1;
            end else if (target == 8'sh00) begin
                nph  = IDLE;
                nacc = '0;
            end
        end
    endcase
    if (nph != ph) m_start[n] = acc_level(m_acc[n]);
    m_phase[n] = nph;
    m_acc[n]   = nacc;
    if (s.env == env_t'(MAIN_ENV)) m_free[s.voice] = (nph == IDLE) || (nph == LEVEL4);
    lvl = acc_level(nacc);
    fr  = m_free;
endfunction

//--- sim/env_gen_tb.sv
/*
 * Envelope generator testbench.
 * Register tests, random envelopes vs the model, watchdog.
 */
module env_gen_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import env_pkg::*;

    localparam int TOTAL_CYCLES = 42600;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * 40 * 3 / 2;

    typedef struct packed {
        level_t      lvl;
        voice_mask_t fr;
    } expect_t;

    logic sCLK_XVXENVS, reset_data_N;
    logic reg_write, reg_read, ready;
    param_adr_t  reg_adr;
    param_byte_t reg_wdata, reg_rdata;
    slot_t       slot, prev_slot;
    voice_mask_t keys_on, keys, voice_free;
    level_t      level_mul;
    expect_t     exp_q[$];
    logic        have_prev, pend_wr, rd_pending;
    param_adr_t  pend_adr;
    param_byte_t pend_wd, rd_expect;
    logic [2:0]  rr;
    int          seed = 32'h88f3;

    `include "env_model.svh"

    env_clock_gen clk_gen (.sCLK_XVXENVS(sCLK_XVXENVS), .reset_data_N(reset_data_N));

    env_gen_top uut (.*);

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_level(input string name, input level_t got, input level_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_mask(input string name, input voice_mask_t got,
                              input voice_mask_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_byte(input string name, input param_byte_t got,
                              input param_byte_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // one clock of checks, new inputs and model update
    task automatic run_cycle(input logic wr, input logic rd, input param_adr_t adr,
                             input param_byte_t wd);
        expect_t e;
        @(posedge sCLK_XVXENVS);
        #5;
        if (!ready) begin
            $display("ready dropped low after the start-up sweep");
            stop_with_failure();
        end
        if (rd_pending) check_byte("reg_rdata", reg_rdata, rd_expect);
        rd_pending = 1'b0;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_level("level_mul", level_mul, e.lvl);
            check_mask("voice_free", voice_free, e.fr);
        end
        reg_write = wr;
        reg_read  = rd;
        reg_adr   = adr;
        reg_wdata = wd;
        keys_on   = keys;
        slot      = slot_t'(rr);
        rr        = rr + 3'd1;
        if (have_prev) begin
            model_visit(prev_slot, keys, e.lvl, e.fr);
            exp_q.push_back(e);
        end
        if (pend_wr) model_write(pend_adr, pend_wd);   // lands one edge later
        if (rd) begin
            rd_pending = 1'b1;
            rd_expect  = model_read(adr);
        end
        pend_wr   = wr;
        pend_adr  = adr;
        pend_wd   = wd;
        prev_slot = slot;
        have_prev = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) run_cycle(1'b0, 1'b0, '0, '0);
    endtask

    function automatic logic slots_settled(phase_t a, phase_t b, voice_mask_t voices);
        for (int s = 0; s < SLOTS; s++) begin
            if (voices[s / ENVS] && m_phase[s] != a && m_phase[s] != b) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic run_until(input phase_t a, input phase_t b, input voice_mask_t voices,
                             input int cap, input string what);
        int n;
        n = 0;
        while (!slots_settled(a, b, voices)) begin
            if (n == cap) begin
                $display("model never reached %s within %0d cycles", what, cap);
                stop_with_failure();
            end
            run_cycle(1'b0, 1'b0, '0, '0);
            n++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run exceeded %0d ns", WATCHDOG_NS);
        stop_with_failure();
    end

    initial begin
        int          r;
        int          n;
        param_adr_t  adr;
        param_byte_t b;
        voice_mask_t rel;
        {reg_write, reg_read, reg_adr, reg_wdata} = '0;
        slot = '0;
        keys_on = '0;
        keys = '0;
        {have_prev, pend_wr, rd_pending, pend_adr, pend_wd, rd_expect, rr} = '0;
        model_reset();
        @(posedge reset_data_N);
        check_mask("voice_free", voice_free, '1);
        check_level("level_mul", level_mul, 8'sh00);
        check_byte("reg_rdata", reg_rdata, 8'h00);
        n = 0;
        while (!ready) begin
            if (n == SLOTS + 4) begin
                $display("ready did not rise within %0d cycles of reset", SLOTS + 4);
                stop_with_failure();
            end
            @(posedge sCLK_XVXENVS);
            #1;
            n++;
        end
        if (n != SLOTS) begin
            $display("ready rose after %0d cycles instead of %0d", n, SLOTS);
            stop_with_failure();
        end
        for (int a = 0; a < 16; a++) run_cycle(1'b0, 1'b1, param_adr_t'(a), '0);   // defaults
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            adr = {2'b00, r[4:0]};
            b = r[15:8];
            run_cycle(1'b1, 1'b0, adr, b);
            run_cycle(1'b0, 1'b1, adr, '0);
        end
        for (int a = 0; a < 16; a++) begin
            r = $random(seed);
            b = (a[2]) ? r[7:0] : {6'b0, 1'b1, r[8]};   // rates 2..3
            if (b == 8'h00) b = 8'h01;
            run_cycle(1'b1, 1'b0, param_adr_t'(a), b);
        end
        keys = '1;
        run_until(LEVEL3, LEVEL3, '1, 32000, "sustain");
        idle_cycles(64);
        r = $random(seed);
        rel = (r[3:0] == 4'h0) ? 4'b0101 : r[3:0];
        keys = ~rel;
        idle_cycles(80);
        keys = '1;   // retrigger during RATE4
        idle_cycles(16);
        keys = ~rel;
        run_until(LEVEL4, IDLE, rel, 10000, "release end");
        idle_cycles(16);
        keys = '1;   // retrigger from LEVEL4
        idle_cycles(64);
        for (int e = 0; e < ENVS; e++) begin
            for (int i = 0; i < 4; i++) run_cycle(1'b1, 1'b0, param_adr_t'(e * 8 + i), 8'h00);
            run_cycle(1'b1, 1'b0, param_adr_t'(e * 8 + 7), 8'h00);
        end
        idle_cycles(64);
        keys = '0;
        idle_cycles(64);
        if (!slots_settled(IDLE, IDLE, '1)) begin
            $display("slots did not return to idle with zero rates");
            stop_with_failure();
        end else begin
            idle_cycles(3);
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+sim
verilog/env_pkg.sv
verilog/env_param_bank.sv
verilog/env_state_ram.sv
verilog/env_step_calc.sv
verilog/env_phase_fsm.sv
verilog/env_gen_top.sv
sim/env_clock_gen.sv
sim/env_gen_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = env_gen_tb
FILELIST = src.f
BUILD    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
